// File: tb.f
design/vga_pkg.sv
design/sprite_pkg.sv
design/vga_timing.sv
design/draw_background.sv
design/player_state_buffer.sv
design/draw_player.sv
design/game_display.sv
bench/display_properties.sv
bench/tb_top.sv

// File: sprite_rom.hex
// one sprite row per line: eight 12-bit rgb pixels, leftmost pixel first, F00 is see-through
// rows 0-7 archer, 8-15 knight, 16-23 mage, 24-31 rogue
F00F002A22A22A2F00F00F00
F002A2FCAFCA2A2F00840F00
F00F00FCAFCAF00F00F00840
F002A22A22A22A2840840840
F002A22A22A22A2F00F00840
F00F002A22A2F00F00840F00
F00F00531F00531F00F00F00
F00531531F00531531F00F00
F00F00F00C22C22F00F00F00
F00F00AABAABAABAABF00F00
F00F00AAB114AABAABF00F00
888F00AABAABAABAABF00F00
888AABAABAABAABAABAABF00
888F00AABAABAABAABF00F00
F00F00AABF00F00AABF00F00
F00444444F00F00444444F00
F00F00F0062CF00F00F00FF4
F00F0062C62C62CF00F00963
F00F00FCAFCAFCAF00F00963
F0062C62C62C62C62C62C963
F00F0062C62C62CF00F00963
F00F0062C62C62CF00F00963
F0062C62C62C62C62CF00963
62C62C62C62C62C62C62C963
F00F00333333333F00F00F00
F00333333333333333F00F00
F003330F03330F0333F00F00
F00F00333FCA333F00F00F00
F00333333333333333CCCF00
F00333333333333F00CCCF00
F00F00333F00333F00F00F00
F00222F00F00F00222F00F00

// File: bench/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top
    import vga_pkg::*;
    import sprite_pkg::*;
();

    typedef struct packed {
        logic [31:0] id;
        logic [11:0] x;
        logic [11:0] y;
        logic        flip;
        logic [1:0]  cls;
    } upd_t;

    logic               clk;
    logic               rst;
    logic               player_valid;
    logic [11:0]        player_x;
    logic [11:0]        player_y;
    logic               player_flip;
    player_class_t      player_class;
    logic [count_w-1:0] hcount;
    logic [count_w-1:0] vcount;
    logic               hsync;
    logic               vsync;
    logic               hblnk;
    logic               vblnk;
    logic [11:0]        rgb;

    logic [sprite_cols*12-1:0] rom [0:sprite_rows*4-1];
    logic [31:0] lfsr;
    logic [31:0] next_id;
    // latest accepted update, and as it stood one and two drives earlier
    upd_t        cur;
    upd_t        lag1;
    upd_t        lag2;
    upd_t        active;
    logic        shown;
    logic [3:0]  seen;

    game_display dut_i (
        .clk          (clk),
        .rst          (rst),
        .player_valid (player_valid),
        .player_x     (player_x),
        .player_y     (player_y),
        .player_flip  (player_flip),
        .player_class (player_class),
        .hcount       (hcount),
        .vcount       (vcount),
        .hsync        (hsync),
        .vsync        (vsync),
        .hblnk        (hblnk),
        .vblnk        (vblnk),
        .rgb          (rgb)
    );

    bind game_display display_properties props_i (
        .clk    (clk),
        .rst    (rst),
        .hcount (hcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .hblnk  (hblnk),
        .vblnk  (vblnk),
        .rgb    (rgb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ****************************************
    // failure reporting
    // ****************************************
    task automatic fail_and_stop();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic value_mismatch(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        fail_and_stop();
    endtask

    task automatic run_failed(input string msg);
        $display("%s", msg);
        fail_and_stop();
    endtask

    // ****************************************
    // stimulus
    // ****************************************
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic send_update(input logic [11:0] x, input logic [11:0] y,
                               input logic flip, input logic [1:0] cls);
        player_valid = 1'b1;
        player_x     = x;
        player_y     = y;
        player_flip  = flip;
        player_class = player_class_t'(cls);
        // the buffer drops an update at the origin
        if (x != 12'd0 || y != 12'd0) begin
            cur = '{id: next_id, x: x, y: y, flip: flip, cls: cls};
            next_id++;
        end
    endtask

    task automatic random_update(input logic at_origin, input logic set_cls,
                                 input logic [1:0] cls);
        logic [31:0] rx;
        logic [31:0] ry;
        logic [31:0] fl;
        logic [31:0] rc;
        take_bits(10, rx);
        take_bits(10, ry);
        take_bits(1, fl);
        take_bits(2, rc);
        if (set_cls) begin
            rc = {30'd0, cls};
        end
        if (at_origin) begin
            send_update(12'd0, 12'd0, fl[0], rc[1:0]);
        end else begin
            // keep the whole 16x16 box on screen
            send_update(12'(half_w + rx % (h_visible - 2 * half_w)),
                        12'(half_h + ry % (v_visible - 2 * half_h)), fl[0], rc[1:0]);
        end
    endtask

    // ****************************************
    // reference model of the pixel stream
    // ****************************************
    function automatic logic [11:0] expected_rgb(input int h, input int v);
        int          rx;
        int          ry;
        int          col;
        int          row;
        logic [11:0] pix;
        logic [11:0] spr;
        if (h >= h_visible || v >= v_visible) begin
            return 12'h000;
        end
        pix = band_colour[h / band_width];
        rx  = h - (int'(active.x) - half_w);
        ry  = v - (int'(active.y) - half_h);
        if (shown && rx >= 0 && rx < 2 * half_w && ry >= 0 && ry < 2 * half_h) begin
            col = rx / sprite_scale;
            if (active.flip) begin
                col = sprite_cols - 1 - col;
            end
            row = int'(active.cls) * sprite_rows + ry / sprite_scale;
            spr = rom[row][sprite_cols * 12 - 1 - 12 * col -: 12];
            if (spr != transparent_rgb) begin
                pix = spr;
            end
        end
        return pix;
    endfunction

    initial begin
        int          cycles;
        int          frame_no;
        int          exp_h;
        int          exp_v;
        logic [11:0] exp_rgb;
        logic [31:0] r;
        $readmemh(rom_file, rom);
        lfsr         = 32'hbba5;
        next_id      = 32'd1;
        cur          = '0;
        lag1         = '0;
        lag2         = '0;
        active       = '0;
        shown        = 1'b0;
        seen         = 4'b0000;
        rst          = 1'b1;
        player_valid = 1'b0;
        player_x     = 12'd0;
        player_y     = 12'd0;
        player_flip  = 1'b0;
        player_class = class_archer;

        repeat (16) @(negedge clk);
        assert (!hsync && !vsync && !hblnk && !vblnk && rgb == 12'h000)
            else value_mismatch("outputs not low during reset");
        rst = 1'b0;

        // pipeline still shows reset values for a couple of cycles
        cycles = 0;
        while (hcount == '0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 8) begin
                run_failed("hcount did not start counting after reset");
            end
        end

        exp_h    = 1;
        exp_v    = 0;
        frame_no = 0;
        cycles   = 0;
        while (frame_no < 5) begin
            // the buffer swaps in the update held before the frame start edge
            if (exp_h == 0 && exp_v == 0) begin
                frame_no++;
                if (lag2.id != 0) begin
                    active = lag2;
                    shown  = 1'b1;
                    seen[active.cls] = 1'b1;
                end
            end
            assert (hcount == exp_h && vcount == exp_v)
                else value_mismatch($sformatf("count %0d,%0d expected %0d,%0d",
                                              hcount, vcount, exp_h, exp_v));
            assert (hblnk == (exp_h >= h_visible) &&
                    hsync == (exp_h >= h_visible + h_front &&
                              exp_h < h_visible + h_front + h_sync))
                else value_mismatch($sformatf("hblnk %b hsync %b at hcount %0d",
                                              hblnk, hsync, exp_h));
            assert (vblnk == (exp_v >= v_visible) &&
                    vsync == (exp_v >= v_visible + v_front &&
                              exp_v < v_visible + v_front + v_sync))
                else value_mismatch($sformatf("vblnk %b vsync %b at vcount %0d",
                                              vblnk, vsync, exp_v));
            exp_rgb = expected_rgb(exp_h, exp_v);
            assert (rgb == exp_rgb)
                else value_mismatch($sformatf("rgb %h at %0d,%0d expected %h",
                                              rgb, exp_h, exp_v, exp_rgb));
            assert (dut_i.props_i.fail_count == 0)
                else run_failed("a display property assertion failed");

            player_valid = 1'b0;
            lag2 = lag1;
            lag1 = cur;
            if (frame_no < 4) begin
                if (exp_h == 500 && exp_v < 610) begin
                    take_bits(5, r);
                    if (r < 2) begin
                        random_update(r == 0, 1'b0, 2'd0);
                    end
                end
                // last update of the frame picks the class, so all four get drawn
                if (exp_h == 500 && exp_v == 620) begin
                    random_update(1'b0, 1'b1, 2'(frame_no));
                end
                if (exp_h == 500 && exp_v == 622) begin
                    random_update(1'b1, 1'b0, 2'd0);
                end
                // sampled on the frame start edge itself
                if (exp_h == h_total - 2 && exp_v == v_total - 1) begin
                    random_update(1'b0, 1'b0, 2'd0);
                end
            end

            @(negedge clk);
            if (exp_h == h_total - 1) begin
                exp_h = 0;
                exp_v = (exp_v == v_total - 1) ? 0 : exp_v + 1;
            end else begin
                exp_h++;
            end
            cycles++;
            if (cycles > 6 * h_total * v_total) begin
                run_failed("timeout waiting for five frames to complete");
            end
        end

        assert (seen == 4'b1111)
            else run_failed("not every player class was drawn");
        if (dut_i.props_i.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            run_failed("a display property assertion failed");
        end
    end

endmodule

`default_nettype wire

// File: bench/display_properties.sv
`timescale 1ns/1ns
`default_nettype none

module display_properties
    import vga_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic [count_w-1:0] hcount,
    input logic               hsync,
    input logic               vsync,
    input logic               hblnk,
    input logic               vblnk,
    input logic [11:0]        rgb
);

    // read by the testbench after every pixel
    int fail_count = 0;

    // ****************************************
    // sync and blanking
    // ****************************************
    hsync_in_hblnk: assert property (@(posedge clk) disable iff (rst) hsync |-> hblnk)
        else begin
            fail_count++;
            $error("hsync high outside horizontal blanking");
        end

    vsync_in_vblnk: assert property (@(posedge clk) disable iff (rst) vsync |-> vblnk)
        else begin
            fail_count++;
            $error("vsync high outside vertical blanking");
        end

    hcount_range: assert property (@(posedge clk) disable iff (rst) hcount < h_total)
        else begin
            fail_count++;
            $error("hcount reached the line length");
        end

    black_in_blank: assert property (@(posedge clk) disable iff (rst)
                                     (hblnk || vblnk) |-> (rgb == 12'h000))
        else begin
            fail_count++;
            $error("rgb not black during blanking");
        end

endmodule

`default_nettype wire

// File: design/game_display.sv
`timescale 1ns/1ns
`default_nettype none

module game_display
    import vga_pkg::*;
    import sprite_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               player_valid,
    input  logic [11:0]        player_x,
    input  logic [11:0]        player_y,
    input  logic               player_flip,
    input  player_class_t      player_class,
    output logic [count_w-1:0] hcount,
    output logic [count_w-1:0] vcount,
    output logic               hsync,
    output logic               vsync,
    output logic               hblnk,
    output logic               vblnk,
    output logic [11:0]        rgb
);

    // timing generator outputs
    logic [count_w-1:0] tg_hcount;
    logic [count_w-1:0] tg_vcount;
    logic               tg_hsync;
    logic               tg_vsync;
    logic               tg_hblnk;
    logic               tg_vblnk;
    logic               frame_start;

    // background stage outputs
    logic [count_w-1:0] bg_hcount;
    logic [count_w-1:0] bg_vcount;
    logic               bg_hsync;
    logic               bg_vsync;
    logic               bg_hblnk;
    logic               bg_vblnk;
    logic [11:0]        bg_rgb;

    // active player state
    logic [11:0]        draw_x;
    logic [11:0]        draw_y;
    logic               draw_flip;
    player_class_t      draw_class;
    logic               player_shown;

    vga_timing timing_i (
        .clk         (clk),
        .rst         (rst),
        .hcount      (tg_hcount),
        .vcount      (tg_vcount),
        .hsync       (tg_hsync),
        .vsync       (tg_vsync),
        .hblnk       (tg_hblnk),
        .vblnk       (tg_vblnk),
        .frame_start (frame_start)
    );

    draw_background background_i (
        .clk       (clk),
        .rst       (rst),
        .in_hcount (tg_hcount),
        .in_vcount (tg_vcount),
        .in_hsync  (tg_hsync),
        .in_vsync  (tg_vsync),
        .in_hblnk  (tg_hblnk),
        .in_vblnk  (tg_vblnk),
        .hcount    (bg_hcount),
        .vcount    (bg_vcount),
        .hsync     (bg_hsync),
        .vsync     (bg_vsync),
        .hblnk     (bg_hblnk),
        .vblnk     (bg_vblnk),
        .rgb       (bg_rgb)
    );

    player_state_buffer state_i (
        .clk          (clk),
        .rst          (rst),
        .frame_start  (frame_start),
        .player_valid (player_valid),
        .player_x     (player_x),
        .player_y     (player_y),
        .player_flip  (player_flip),
        .player_class (player_class),
        .draw_x       (draw_x),
        .draw_y       (draw_y),
        .draw_flip    (draw_flip),
        .draw_class   (draw_class),
        .player_shown (player_shown)
    );

    draw_player sprite_i (
        .clk          (clk),
        .rst          (rst),
        .in_hcount    (bg_hcount),
        .in_vcount    (bg_vcount),
        .in_hsync     (bg_hsync),
        .in_vsync     (bg_vsync),
        .in_hblnk     (bg_hblnk),
        .in_vblnk     (bg_vblnk),
        .in_rgb       (bg_rgb),
        .draw_x       (draw_x),
        .draw_y       (draw_y),
        .draw_flip    (draw_flip),
        .draw_class   (draw_class),
        .player_shown (player_shown),
        .hcount       (hcount),
        .vcount       (vcount),
        .hsync        (hsync),
        .vsync        (vsync),
        .hblnk        (hblnk),
        .vblnk        (vblnk),
        .rgb          (rgb)
    );

endmodule

`default_nettype wire

// File: design/draw_player.sv
`timescale 1ns/1ns
`default_nettype none

module draw_player
    import vga_pkg::*;
    import sprite_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [count_w-1:0] in_hcount,
    input  logic [count_w-1:0] in_vcount,
    input  logic               in_hsync,
    input  logic               in_vsync,
    input  logic               in_hblnk,
    input  logic               in_vblnk,
    input  logic [11:0]        in_rgb,
    input  logic [11:0]        draw_x,
    input  logic [11:0]        draw_y,
    input  logic               draw_flip,
    input  player_class_t      draw_class,
    input  logic               player_shown,
    output logic [count_w-1:0] hcount,
    output logic [count_w-1:0] vcount,
    output logic               hsync,
    output logic               vsync,
    output logic               hblnk,
    output logic               vblnk,
    output logic [11:0]        rgb
);

    // one row of eight pixels per entry, four classes stacked
    logic [sprite_cols*12-1:0] sprite_rom [0:sprite_rows*4-1];

    logic [11:0] h_pos;
    logic [11:0] v_pos;
    logic [11:0] x_lo;
    logic [11:0] y_lo;
    logic [11:0] rel_x;
    logic [11:0] rel_y;
    logic        in_box;
    logic [2:0]  src_col;
    logic [2:0]  src_row;
    logic [4:0]  rom_row;
    logic [11:0] rom_pix;
    logic [11:0] rgb_nxt;

    initial begin
        $readmemh(rom_file, sprite_rom);
    end

    // ****************************************
    // box test and rom lookup
    // ****************************************
    always_comb begin
        h_pos  = {1'b0, in_hcount};
        v_pos  = {1'b0, in_vcount};
        x_lo   = draw_x - 12'(half_w);
        y_lo   = draw_y - 12'(half_h);
        rel_x  = h_pos - x_lo;
        rel_y  = v_pos - y_lo;
        in_box = (h_pos >= x_lo) && (h_pos < draw_x + 12'(half_w)) &&
                 (v_pos >= y_lo) && (v_pos < draw_y + 12'(half_h));

        // each source pixel covers a 2x2 screen block
        src_col = 3'(rel_x / sprite_scale);
        if (draw_flip) begin
            src_col = 3'(sprite_cols - 1) - src_col;
        end
        src_row = 3'(rel_y / sprite_scale);
        rom_row = 5'(draw_class * sprite_rows + src_row);

        // leftmost pixel sits in the top bits
        rom_pix = sprite_rom[rom_row][(sprite_cols - 1 - src_col) * 12 +: 12];

        rgb_nxt = in_rgb;
        if (player_shown && !in_hblnk && !in_vblnk && in_box &&
            (rom_pix != transparent_rgb)) begin
            rgb_nxt = rom_pix;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= 12'h000;
        end else begin
            hcount <= in_hcount;
            vcount <= in_vcount;
            hsync  <= in_hsync;
            vsync  <= in_vsync;
            hblnk  <= in_hblnk;
            vblnk  <= in_vblnk;
            rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: design/player_state_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module player_state_buffer
    import sprite_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          frame_start,
    input  logic          player_valid,
    input  logic [11:0]   player_x,
    input  logic [11:0]   player_y,
    input  logic          player_flip,
    input  player_class_t player_class,
    output logic [11:0]   draw_x,
    output logic [11:0]   draw_y,
    output logic          draw_flip,
    output player_class_t draw_class,
    output logic          player_shown
);

    logic          accept;
    logic [11:0]   pend_x;
    logic [11:0]   pend_y;
    logic          pend_flip;
    player_class_t pend_class;
    logic          pend_valid;

    // an update at the origin carries no position
    assign accept = player_valid && ((player_x != '0) || (player_y != '0));

    // ****************************************
    // pending set
    // ****************************************
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_x     <= player_x;
            pend_y     <= player_y;
            pend_flip  <= player_flip;
            pend_class <= player_class;
        end
    end

    // a strobe on the frame_start cycle stays pending for the next frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else if (accept) begin
            pend_valid <= 1'b1;
        end else if (frame_start) begin
            pend_valid <= 1'b0;
        end
    end

    // ****************************************
    // active set, swapped only between frames
    // ****************************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draw_x       <= '0;
            draw_y       <= '0;
            draw_flip    <= 1'b0;
            draw_class   <= class_archer;
            player_shown <= 1'b0;
        end else if (frame_start && pend_valid) begin
            draw_x       <= pend_x;
            draw_y       <= pend_y;
            draw_flip    <= pend_flip;
            draw_class   <= pend_class;
            player_shown <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/draw_background.sv
`timescale 1ns/1ns
`default_nettype none

module draw_background
    import vga_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [count_w-1:0] in_hcount,
    input  logic [count_w-1:0] in_vcount,
    input  logic               in_hsync,
    input  logic               in_vsync,
    input  logic               in_hblnk,
    input  logic               in_vblnk,
    output logic [count_w-1:0] hcount,
    output logic [count_w-1:0] vcount,
    output logic               hsync,
    output logic               vsync,
    output logic               hblnk,
    output logic               vblnk,
    output logic [11:0]        rgb
);

    logic [2:0] band_idx;

    // only meaningful in the visible area, blanking overrides it
    assign band_idx = 3'(in_hcount / band_width);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= 12'h000;
        end else begin
            hcount <= in_hcount;
            vcount <= in_vcount;
            hsync  <= in_hsync;
            vsync  <= in_vsync;
            hblnk  <= in_hblnk;
            vblnk  <= in_vblnk;
            rgb    <= (in_hblnk || in_vblnk) ? 12'h000 : band_colour[band_idx];
        end
    end

endmodule

`default_nettype wire

// File: design/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vga_timing
    import vga_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    output logic [count_w-1:0] hcount,
    output logic [count_w-1:0] vcount,
    output logic               hsync,
    output logic               vsync,
    output logic               hblnk,
    output logic               vblnk,
    output logic               frame_start
);

    logic [count_w-1:0] h_nxt;
    logic [count_w-1:0] v_nxt;

    // ****************************************
    // counters
    // ****************************************
    always_comb begin
        h_nxt = hcount + 1'b1;
        v_nxt = vcount;
        if (hcount == count_w'(h_total - 1)) begin
            h_nxt = '0;
            if (vcount == count_w'(v_total - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = vcount + 1'b1;
            end
        end
    end

    // flags decoded from the next count so they line up with it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount      <= '0;
            vcount      <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            hblnk       <= 1'b0;
            vblnk       <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            hcount      <= h_nxt;
            vcount      <= v_nxt;
            hblnk       <= (h_nxt >= h_visible);
            hsync       <= (h_nxt >= h_visible + h_front) &&
                           (h_nxt <  h_visible + h_front + h_sync);
            vblnk       <= (v_nxt >= v_visible);
            vsync       <= (v_nxt >= v_visible + v_front) &&
                           (v_nxt <  v_visible + v_front + v_sync);
            frame_start <= (h_nxt == '0) && (v_nxt == '0);
        end
    end

endmodule

`default_nettype wire

// File: design/sprite_pkg.sv
`default_nettype none

package sprite_pkg;

    // ****************************************
    // sprite format
    // ****************************************

    // source pixels, 12 bit rgb each
    localparam int sprite_cols  = 8;
    localparam int sprite_rows  = 8;
    localparam int sprite_scale = 2;

    // half of the drawn 16x16 box, in screen pixels
    localparam int half_w = sprite_cols * sprite_scale / 2;
    localparam int half_h = sprite_rows * sprite_scale / 2;

    // pure red marks a see-through pixel
    localparam logic [11:0] transparent_rgb = 12'hF00;

    localparam string rom_file = "sprite_rom.hex";

    // picks a block of sprite_rows rom rows
    typedef enum logic [1:0] {
        class_archer,
        class_knight,
        class_mage,
        class_rogue
    } player_class_t;

endpackage

`default_nettype wire

// File: design/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // ****************************************
    // 800x600 at 60 Hz, 40 MHz pixel clock
    // ****************************************

    // horizontal, in pixels
    localparam int h_visible = 800;
    localparam int h_front   = 40;
    localparam int h_sync    = 128;
    localparam int h_total   = 1056;

    // vertical, in lines
    localparam int v_visible = 600;
    localparam int v_front   = 1;
    localparam int v_sync    = 4;
    localparam int v_total   = 628;

    localparam int count_w = 11;

    // ****************************************
    // background
    // ****************************************
    localparam int band_width = 100;

    localparam logic [11:0] band_colour [8] = '{
        12'h226, 12'h3A4, 12'hFC2, 12'h0CF,
        12'hC3C, 12'h8F0, 12'hF80, 12'h555
    };

endpackage

`default_nettype wire
